//--- all.f
verilog/cache_pkg.sv
verilog/cache_arrays.sv
verilog/cache_mem_port.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
dv/tb_clock.sv
dv/cache_properties.sv
dv/cache_tb.sv

//--- dv/cache_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cache_properties (
    input logic clk,
    input logic resetn,
    input logic addr_ok,
    input logic data_ok,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req,
    input logic wr_rdy
);

    // read request held until memory takes it
    rd_req_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    wr_req_needs_rdy: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |-> wr_rdy)
        else $error("wr_req raised without wr_rdy");

    wr_req_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |=> !wr_req)  // write-back is a single pulse
        else $error("wr_req held for more than one cycle");

    // addr_ok marks idle
    no_data_ok_idle: assert property (@(posedge clk) disable iff (!resetn)
        addr_ok |-> !data_ok)
        else $error("data_ok while the controller is idle");

endmodule

bind cache_ctrl cache_properties u_props (
    .clk    (clk),
    .resetn (resetn),
    .addr_ok(addr_ok),
    .data_ok(data_ok),
    .rd_req (rd_req),
    .rd_rdy (rd_rdy),
    .wr_req (wr_req),
    .wr_rdy (wr_rdy)
);

`default_nettype wire

//--- dv/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb import cache_pkg::*; ();

    localparam word_t seed         = 32'heba3;
    localparam int    num_random   = 400;
    localparam int    num_directed = 24;
    localparam int    max_cycles   = (num_random + num_directed) * 40 + 20;

    logic    clk;
    logic    resetn;
    logic    valid;
    logic    op;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    strb_t   wstrb;
    word_t   wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    rd_req;
    addr_t   rd_addr;
    logic    rd_rdy;
    logic    ret_valid;
    logic    ret_last;
    word_t   ret_data;
    logic    wr_req;
    addr_t   wr_addr;
    line_t   wr_data;
    logic    wr_rdy;

    logic [7:0] shadow [addr_t];     // every byte the cpu wrote
    word_t      mem_words [addr_t];  // sparse memory holding written-back words only
    word_t      stim_rng;
    word_t      mem_rng;
    int         wb_count;
    int         n_accepted;
    int         n_done;
    int         errors;
    int         cycle;
    bit         expect_hit;
    bit         pending;
    logic       pend_op;
    word_t      pend_exp;
    bit         pend_hit;
    int         pend_cycle;
    bit         saw_rd;

    tb_clock u_clock (.clk(clk), .resetn(resetn));

    cache_top u_dut (.*);

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory contents before any write
    function automatic word_t init_word(input addr_t a);
        return a ^ 32'hc3a5_5a3c;
    endfunction

    function automatic word_t mem_read(input addr_t a);
        return mem_words.exists(a) ? mem_words[a] : init_word(a);
    endfunction

    function automatic word_t expected_read(input addr_t a);
        addr_t base;
        word_t w;
        base = {a[31:2], 2'b00};
        w    = init_word(base);
        for (int i = 0; i < 4; i++) begin
            if (shadow.exists(base + addr_t'(i))) w[8*i +: 8] = shadow[base + addr_t'(i)];
        end
        return w;
    endfunction

    task automatic report_mismatch(input string name, input line_t got, input line_t exp);
        errors++;
        $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        $display("Simulation failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "check failed");
    endtask

    // issues one request and returns on the rising edge after its data_ok
    task automatic access(input logic wr, input addr_t a, input strb_t strb, input word_t d,
                          input bit hit);
        expect_hit = hit;
        valid  <= 1'b1;
        op     <= wr;
        tag    <= a[31:12];
        index  <= a[11:4];
        offset <= a[3:0];
        wstrb  <= strb;
        wdata  <= d;
        do
            @(negedge clk);
        while (!addr_ok);
        @(posedge clk);
        valid <= 1'b0;
        do
            @(negedge clk);
        while (!data_ok);
        @(posedge clk);
    endtask

    initial begin : stimulus
        word_t r;
        addr_t a;
        int    wb_before;
        valid    = 1'b0;
        op       = 1'b0;
        index    = '0;
        tag      = '0;
        offset   = '0;
        wstrb    = '0;
        wdata    = '0;
        stim_rng = seed;
        do
            @(negedge clk);
        while (!resetn);
        @(posedge clk);

        // untouched line then hits on two of its banks
        a = 32'h1234_5018;
        access(1'b0, a, 4'h0, '0, 1'b0);
        access(1'b0, a, 4'h0, '0, 1'b1);
        access(1'b0, a - 32'd8, 4'h0, '0, 1'b1);

        // write miss then write hit with a reread after each
        a = 32'h2222_210c;
        stim_rng = xorshift(stim_rng);
        access(1'b1, a, stim_rng[3:0], xorshift(stim_rng), 1'b0);
        access(1'b0, a, 4'h0, '0, 1'b1);
        stim_rng = xorshift(stim_rng);
        access(1'b1, a, stim_rng[7:4], xorshift(stim_rng), 1'b1);
        access(1'b0, a, 4'h0, '0, 1'b1);

        // three dirty tags in one set
        wb_before = wb_count;
        for (int t = 0; t < 3; t++) begin
            stim_rng = xorshift(stim_rng);
            access(1'b1, {20'h30000 + 20'(t), 8'h20, 4'h4}, 4'hf, stim_rng, 1'b0);
        end
        assert (wb_count > wb_before) else report_failure("no write-back after three dirty tags");
        for (int t = 0; t < 3; t++) begin
            access(1'b0, {20'h30000 + 20'(t), 8'h20, 4'h4}, 4'h0, '0, 1'b0);
        end

        // clean victims only
        wb_before = wb_count;
        for (int t = 0; t < 3; t++) begin
            access(1'b0, {20'h40000 + 20'(t), 8'h30, 4'h0}, 4'h0, '0, 1'b0);
        end
        assert (wb_count == wb_before) else report_failure("write-back of a clean victim");

        // random mix over four tags and eight sets
        for (int n = 0; n < num_random; n++) begin
            stim_rng = xorshift(stim_rng);
            r = stim_rng;
            a = {20'h0a000 + 20'(r[1:0]), 8'h40 + 8'(r[4:2]), r[6:5], 2'b00};
            stim_rng = xorshift(stim_rng);
            access(r[7], a, r[11:8], stim_rng, 1'b0);
        end

        // idle tail so a stray data_ok still reaches the monitor
        repeat (8) @(posedge clk);

        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // compares every response on the falling edge
    always @(negedge clk) begin : monitor
        addr_t a;
        if (resetn) begin
            cycle++;
            if (rd_req) saw_rd = 1'b1;
            assert (!(pending && addr_ok))
                else report_failure("addr_ok high while a request was outstanding");
            if (data_ok) begin
                assert (pending) else report_failure("data_ok without an accepted request");
                if (!pend_op) begin
                    assert (rdata === pend_exp) else report_mismatch("rdata", rdata, pend_exp);
                end
                if (pend_hit) begin
                    assert (cycle - pend_cycle == 1)
                        else report_failure("hit did not answer one cycle after acceptance");
                    assert (!saw_rd) else report_failure("rd_req issued for an expected hit");
                end
                pending = 1'b0;
                n_done++;
            end
            if (valid && addr_ok) begin
                a          = {tag, index, offset[3:2], 2'b00};
                pending    = 1'b1;
                pend_op    = op;
                pend_exp   = expected_read(a);
                pend_hit   = expect_hit;
                pend_cycle = cycle;
                saw_rd     = 1'b0;
                n_accepted++;
                for (int i = 0; i < 4; i++) begin
                    if (op && wstrb[i]) shadow[a + addr_t'(i)] = wdata[8*i +: 8];
                end
            end
        end
    end

    initial begin : memory_model
        addr_t line_addr;
        int    beat_no;
        bit    busy;
        word_t got;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        mem_rng   = seed ^ 32'h9e37_79b9;
        busy      = 1'b0;
        beat_no   = 0;
        line_addr = '0;
        forever begin
            @(negedge clk);
            if (resetn && wr_req) begin
                // victim sits in the requested set and is another line
                assert (wr_addr[11:0] === {index, 4'h0})
                    else report_mismatch("wr_addr[11:0]", wr_addr[11:0], {index, 4'h0});
                assert (wr_addr[31:12] !== tag)
                    else report_failure("write-back of the line being requested");
                for (int i = 0; i < num_banks; i++) begin
                    got = wr_data[32*i +: 32];
                    assert (got === expected_read(wr_addr + addr_t'(4*i)))
                        else report_mismatch("wr_data", got, expected_read(wr_addr + addr_t'(4*i)));
                    mem_words[wr_addr + addr_t'(4*i)] = got;
                end
                wb_count++;
            end
            if (resetn && rd_req && rd_rdy) begin
                assert (rd_addr === {tag, index, 4'h0})
                    else report_mismatch("rd_addr", rd_addr, {tag, index, 4'h0});
                line_addr = rd_addr;
                beat_no   = 0;
                busy      = 1'b1;
            end
            if (ret_valid) begin
                beat_no++;
                if (ret_last) busy = 1'b0;
            end
            @(posedge clk);
            mem_rng = xorshift(mem_rng);
            rd_rdy    <= |mem_rng[1:0];  // ready three cycles in four
            wr_rdy    <= |mem_rng[3:2];
            ret_valid <= busy && |mem_rng[5:4];
            ret_last  <= busy && (beat_no == num_banks - 1);
            ret_data  <= mem_read(line_addr + addr_t'(4*beat_no));
        end
    end

    initial begin : watchdog
        #(max_cycles * 4);
        $display("Error at %0t ns: watchdog expired before the test sequence finished", $time);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // synchronous reset, low for ten rising edges
    initial begin
        resetn = 1'b0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build the cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f all.f -o cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/cache_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

//--- verilog/cache_arrays.sv
`timescale 1ns/1ps
`default_nettype none

module cache_arrays import cache_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  index_t                arr_index,
    input  logic [num_ways-1:0]   tag_we,
    input  tag_t                  tag_wr,
    input  strb_t                 bank_we [num_ways][num_banks],
    input  word_t                 bank_wr,
    input  logic [num_ways-1:0]   dirty_we,
    input  logic                  dirty_wr,
    input  logic                  repl_we,
    input  logic                  repl_wr,
    output logic [$bits(tag_t):0] tagv_rd [num_ways],
    output logic [num_ways-1:0]   dirty_rd,
    output logic                  repl_rd,
    output word_t                 bank_rd [num_ways][num_banks]
);

    localparam int num_sets = 2 ** $bits(index_t);

    logic [num_sets-1:0] repl_bits;

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        tag_t                tag_mem [num_sets];
        logic [num_sets-1:0] valid_bits;
        logic [num_sets-1:0] dirty_bits;

        always_ff @(posedge clk) begin
            if (tag_we[w]) tag_mem[arr_index] <= tag_wr;
        end

        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_bits <= '0;
                dirty_bits <= '0;
            end else begin
                if (tag_we[w])   valid_bits[arr_index] <= 1'b1;  // only refills write tags
                if (dirty_we[w]) dirty_bits[arr_index] <= dirty_wr;
            end
        end

        // registered read, one cycle after the index
        always_ff @(posedge clk) begin
            tagv_rd[w]  <= {tag_mem[arr_index], valid_bits[arr_index]};
            dirty_rd[w] <= dirty_bits[arr_index];
        end

        for (genvar b = 0; b < num_banks; b++) begin : g_bank
            word_t mem [num_sets];

            always_ff @(posedge clk) begin
                for (int i = 0; i < $bits(strb_t); i++) begin
                    if (bank_we[w][b][i]) mem[arr_index][8*i +: 8] <= bank_wr[8*i +: 8];
                end
                bank_rd[w][b] <= mem[arr_index];  // old data on a same-cycle write
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)      repl_bits <= '0;
        else if (repl_we) repl_bits[arr_index] <= repl_wr;
    end

    always_ff @(posedge clk) begin
        repl_rd <= repl_bits[arr_index];
    end

endmodule

`default_nettype wire

//--- verilog/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import cache_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    // cpu side
    input  logic                  valid,
    input  logic                  op,           // 1 write
    input  index_t                index,
    input  tag_t                  tag,
    input  offset_t               offset,
    input  strb_t                 wstrb,
    input  word_t                 wdata,
    output logic                  addr_ok,
    output logic                  data_ok,
    output word_t                 rdata,
    // memory requests
    output logic                  rd_req,
    output addr_t                 rd_addr,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  logic                  ret_last,
    output logic                  wr_req,
    output addr_t                 wr_addr,
    output line_t                 wr_data,
    input  logic                  wr_rdy,
    // arrays
    output index_t                arr_index,
    input  logic [$bits(tag_t):0] tagv_rd [num_ways], // {tag, valid}
    input  logic [num_ways-1:0]   dirty_rd,
    input  logic                  repl_rd,
    input  word_t                 bank_rd [num_ways][num_banks],
    output logic [num_ways-1:0]   tag_we,
    output tag_t                  tag_wr,
    output strb_t                 bank_we [num_ways][num_banks],
    output word_t                 bank_wr,
    output logic [num_ways-1:0]   dirty_we,
    output logic                  dirty_wr,
    output logic                  repl_we,
    output logic                  repl_wr,
    // memory port
    output logic                  refill_active,
    output offset_t               req_offset,
    output strb_t                 req_wstrb,
    output word_t                 req_wdata,
    input  bank_sel_t             beat,
    input  word_t                 fill_word,
    input  word_t                 req_word
);

    typedef enum logic [2:0] {st_idle, st_lookup, st_miss, st_replace, st_refill} state_t;

    state_t state, state_nxt;

    logic    op_r;
    index_t  index_r;
    tag_t    tag_r;
    offset_t offset_r;
    strb_t   wstrb_r;
    word_t   wdata_r;

    logic [num_ways-1:0] hit_way;
    logic      cache_hit;
    logic      hit_sel;
    logic      victim;
    logic      victim_dirty;
    logic      refill_we;
    logic      last_beat;
    bank_sel_t bank_r;

    always_ff @(posedge clk) begin
        if (!resetn) state <= st_idle;
        else         state <= state_nxt;
    end

    // request register, loaded on acceptance
    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            op_r     <= op;
            index_r  <= index;
            tag_r    <= tag;
            offset_r <= offset;
            wstrb_r  <= wstrb;
            wdata_r  <= wdata;
        end
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_way[w] = tagv_rd[w][0] && (tagv_rd[w][$bits(tag_t):1] == tag_r);
        end
    end

    assign cache_hit    = |hit_way;
    assign hit_sel      = hit_way[1];
    assign victim       = repl_rd;  // stable until the last beat toggles it
    assign victim_dirty = tagv_rd[victim][0] && dirty_rd[victim];
    assign bank_r       = offset_r[3:2];
    assign refill_we    = (state == st_refill) && ret_valid;
    assign last_beat    = refill_we && ret_last;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:    if (valid) state_nxt = st_lookup;
            st_lookup: begin
                if (cache_hit)         state_nxt = st_idle;
                else if (victim_dirty) state_nxt = st_miss;
                else                   state_nxt = st_replace;
            end
            st_miss:    if (wr_rdy) state_nxt = st_replace;  // write-back taken
            st_replace: if (rd_rdy) state_nxt = st_refill;
            st_refill:  if (last_beat) state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    // cpu handshake
    assign addr_ok = (state == st_idle);
    assign data_ok = ((state == st_lookup) && cache_hit) || last_beat;
    assign rdata   = (state == st_refill) ? req_word : bank_rd[hit_sel][bank_r];

    // memory requests
    assign rd_req  = (state == st_replace);
    assign rd_addr = {tag_r, index_r, 4'b0};
    assign wr_req  = (state == st_miss) && wr_rdy;
    assign wr_addr = {tagv_rd[victim][$bits(tag_t):1], index_r, 4'b0};

    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            wr_data[b*$bits(word_t) +: $bits(word_t)] = bank_rd[victim][b];
        end
    end

    // arrays read the new index while idle, then hold the set
    assign arr_index = (state == st_idle) ? index : index_r;
    assign tag_wr    = tag_r;
    assign bank_wr   = (state == st_refill) ? fill_word : wdata_r;
    assign dirty_wr  = op_r;  // hit writes and write misses both mark dirty
    assign repl_we   = ((state == st_lookup) && cache_hit) || last_beat;
    assign repl_wr   = (state == st_lookup) ? !hit_sel : !victim;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            tag_we[w]   = last_beat && (int'(victim) == w);
            dirty_we[w] = tag_we[w] || ((state == st_lookup) && op_r && hit_way[w]);
            for (int b = 0; b < num_banks; b++) begin
                bank_we[w][b] = '0;
                if ((state == st_lookup) && op_r && hit_way[w] && (bank_r == bank_sel_t'(b)))
                    bank_we[w][b] = wstrb_r;
                if (refill_we && (int'(victim) == w) && (beat == bank_sel_t'(b)))
                    bank_we[w][b] = '1;  // whole beat into the victim way
            end
        end
    end

    // request info for the memory port
    assign refill_active = (state == st_refill);
    assign req_offset    = offset_r;
    assign req_wstrb     = op_r ? wstrb_r : '0;
    assign req_wdata     = wdata_r;

endmodule

`default_nettype wire

//--- verilog/cache_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module cache_mem_port import cache_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      refill_active,
    input  logic      ret_valid,
    input  logic      ret_last,
    input  word_t     ret_data,
    input  offset_t   req_offset,
    input  strb_t     req_wstrb,   // zero for reads
    input  word_t     req_wdata,
    output bank_sel_t beat,
    output word_t     fill_word,
    output word_t     req_word
);

    logic      take;
    logic      req_beat;
    bank_sel_t req_bank;
    word_t     merged;
    word_t     req_word_r;

    assign take     = refill_active && ret_valid;
    assign req_bank = req_offset[3:2];
    assign req_beat = (beat == req_bank);

    // beat counter, back to zero after the last beat
    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat <= '0;
        end else if (take) begin
            if (ret_last || beat == bank_sel_t'(num_banks - 1)) beat <= '0;
            else                                               beat <= beat + 1'b1;
        end
    end

    // store bytes over the returned word
    always_comb begin
        for (int i = 0; i < $bits(strb_t); i++) begin
            merged[8*i +: 8] = req_wstrb[i] ? req_wdata[8*i +: 8] : ret_data[8*i +: 8];
        end
    end

    assign fill_word = req_beat ? merged : ret_data;

    always_ff @(posedge clk) begin
        if (take && req_beat) req_word_r <= ret_data;
    end

    // bypass when the requested word is on the bus now, e.g. on the last beat
    assign req_word = (take && req_beat) ? ret_data : req_word_r;

endmodule

`default_nettype wire

//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // address split: tag [31:12], index [11:4], offset [3:0]
    typedef logic [19:0]  tag_t;
    typedef logic [7:0]   index_t;
    typedef logic [3:0]   offset_t;   // top two bits pick the bank
    typedef logic [1:0]   bank_sel_t; // bank or refill beat
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   strb_t;
    typedef logic [127:0] line_t;     // four words, word 0 in the low bits
    typedef logic [31:0]  addr_t;

    localparam int num_ways  = 2;
    localparam int num_banks = 4;

endpackage

`default_nettype wire

//--- verilog/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    // cpu side
    input  logic    valid,
    input  logic    op,
    input  index_t  index,
    input  tag_t    tag,
    input  offset_t offset,
    input  strb_t   wstrb,
    input  word_t   wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    // memory side
    output logic    rd_req,
    output addr_t   rd_addr,
    input  logic    rd_rdy,
    input  logic    ret_valid,
    input  logic    ret_last,
    input  word_t   ret_data,
    output logic    wr_req,
    output addr_t   wr_addr,
    output line_t   wr_data,
    input  logic    wr_rdy
);

    // controller <-> arrays
    index_t                arr_index;
    logic [$bits(tag_t):0] tagv_rd [num_ways];
    logic [num_ways-1:0]   dirty_rd;
    logic                  repl_rd;
    word_t                 bank_rd [num_ways][num_banks];
    logic [num_ways-1:0]   tag_we;
    tag_t                  tag_wr;
    strb_t                 bank_we [num_ways][num_banks];
    word_t                 bank_wr;
    logic [num_ways-1:0]   dirty_we;
    logic                  dirty_wr;
    logic                  repl_we;
    logic                  repl_wr;

    // controller <-> memory port
    logic      refill_active;
    offset_t   req_offset;
    strb_t     req_wstrb;
    word_t     req_wdata;
    bank_sel_t beat;
    word_t     fill_word;
    word_t     req_word;

    cache_ctrl u_ctrl (.*);

    cache_arrays u_arrays (.*);

    cache_mem_port u_mem_port (.*);

endmodule

`default_nettype wire
